// ==== source/cache_geom_pkg.sv ====
package cache_geom_pkg;

    localparam int ADDR_W         = 32;
    localparam int DATA_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int MAX_LINES      = 16;

    // byte offsets inside a word and inside a line
    localparam int WORD_OFFS_W = $clog2(DATA_W / 8);
    localparam int LINE_OFFS_W = $clog2(WORDS_PER_LINE * DATA_W / 8);

    typedef logic [ADDR_W-1:0]                      addr_t;
    typedef logic [DATA_W-1:0]                      word_t;
    typedef logic [DATA_W/8-1:0]                    strb_t;
    typedef logic [$clog2(MAX_LINES)-1:0]           line_idx_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0]      word_sel_t;
    typedef logic [ADDR_W-LINE_OFFS_W-1:0]          line_addr_t;

    // slot in the upper bits, word in the lower bits
    typedef struct packed {
        line_idx_t slot;
        word_sel_t word;
    } mem_addr_t;

endpackage

// ==== source/cache_msg_pkg.sv ====
package cache_msg_pkg;

    // result of a directory lookup
    typedef enum logic [1:0] {
        hit,
        miss_clean,
        miss_dirty
    } lookup_status_t;

    typedef enum logic {
        op_fill,
        op_writeback
    } line_op_t;

    typedef struct packed {
        cache_geom_pkg::addr_t addr;
        cache_geom_pkg::word_t data;
        cache_geom_pkg::strb_t strb;
    } wr_req_t;

    // command to the outside memory
    typedef struct packed {
        line_op_t                   op;
        cache_geom_pkg::line_addr_t line_addr;
    } fetch_cmd_t;

    // one access to the line store
    typedef struct packed {
        logic                      we;
        cache_geom_pkg::mem_addr_t addr;
        cache_geom_pkg::word_t     data;
        cache_geom_pkg::strb_t     strb;
    } mem_req_t;

endpackage

// ==== source/tag_directory.sv ====
`timescale 1ns/1ps

module tag_directory #(
    parameter int line_count = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  cache_geom_pkg::addr_t          lookup_addr,
    input  logic                           alloc,
    input  logic                           install,
    input  logic                           mark_dirty,
    output cache_msg_pkg::lookup_status_t  status,
    output cache_geom_pkg::line_idx_t      slot,
    output cache_geom_pkg::line_addr_t     victim_addr
);
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    logic [MAX_LINES-1:0] valid_q;
    logic [MAX_LINES-1:0] dirty_q;
    line_addr_t           tag_q [MAX_LINES];
    line_idx_t            ptr_q;
    line_addr_t           lookup_line;
    logic                 is_hit;
    line_idx_t            hit_slot;

    assign lookup_line = lookup_addr[ADDR_W-1:LINE_OFFS_W];

    always_comb begin
        is_hit   = 1'b0;
        hit_slot = '0;
        for (int i = 0; i < line_count; i++) begin
            if (valid_q[i] && tag_q[i] == lookup_line) begin
                is_hit   = 1'b1;
                hit_slot = line_idx_t'(i);
            end
        end
    end

    // on a miss the round-robin pointer names the victim
    assign slot        = is_hit ? hit_slot : ptr_q;
    assign victim_addr = tag_q[ptr_q];

    always_comb begin
        if (is_hit) begin
            status = hit;
        end else if (valid_q[ptr_q] && dirty_q[ptr_q]) begin
            status = miss_dirty;
        end else begin
            status = miss_clean;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            ptr_q   <= '0;
        end else if (alloc) begin
            // victim leaves the directory while it moves
            valid_q[ptr_q] <= 1'b0;
            dirty_q[ptr_q] <= 1'b0;
        end else if (install) begin
            valid_q[ptr_q] <= 1'b1;
            dirty_q[ptr_q] <= 1'b0;
            ptr_q          <= (ptr_q == line_idx_t'(line_count - 1)) ? '0 : ptr_q + 1'b1;
        end else if (mark_dirty) begin
            dirty_q[slot] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tag_q[ptr_q] <= lookup_line;
        end
    end

endmodule

// ==== source/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter #(
    parameter int num_clients = 2
) (
    input  logic [num_clients-1:0]                         req,
    input  cache_msg_pkg::mem_req_t [num_clients-1:0]      acc,
    output logic [num_clients-1:0]                         gnt,
    output cache_msg_pkg::mem_req_t                        mem_acc
);

    logic found;

    // lowest index wins
    always_comb begin
        gnt     = '0;
        mem_acc = '0;
        found   = 1'b0;
        for (int i = 0; i < num_clients; i++) begin
            if (req[i] && !found) begin
                found   = 1'b1;
                gnt[i]  = 1'b1;
                mem_acc = acc[i];
            end
        end
    end

endmodule

// ==== source/line_store.sv ====
`timescale 1ns/1ps

module line_store (
    input  logic                     clk,
    input  cache_msg_pkg::mem_req_t  mem_acc,
    input  logic                     mem_en,
    output cache_geom_pkg::word_t    rdata
);
    import cache_geom_pkg::*;

    word_t mem [WORDS_PER_LINE * MAX_LINES];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_acc.we) begin
                for (int b = 0; b < DATA_W / 8; b++) begin
                    if (mem_acc.strb[b]) begin
                        mem[mem_acc.addr][b*8 +: 8] <= mem_acc.data[b*8 +: 8];
                    end
                end
            end else begin
                rdata <= mem[mem_acc.addr];
            end
        end
    end

endmodule

// ==== source/wr_ctrl.sv ====
`timescale 1ns/1ps

module wr_ctrl #(
    parameter int line_count = 4
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           wr_valid,
    input  cache_msg_pkg::wr_req_t         wr_req,
    input  cache_msg_pkg::lookup_status_t  status,
    input  cache_geom_pkg::line_idx_t      slot,
    input  cache_geom_pkg::line_addr_t     victim_addr,
    input  logic                           move_done,
    input  logic                           gnt,
    output logic                           wr_ready,
    output logic                           wr_done,
    output cache_geom_pkg::addr_t          lookup_addr,
    output logic                           alloc,
    output logic                           install,
    output logic                           mark_dirty,
    output logic                           move_start,
    output cache_msg_pkg::line_op_t        move_op,
    output cache_geom_pkg::line_idx_t      move_slot,
    output cache_geom_pkg::line_addr_t     move_line,
    output logic                           mem_req,
    output cache_msg_pkg::mem_req_t        mem_acc
);
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_move,
        st_install,
        st_write,
        st_done
    } state_t;

    state_t  state;
    state_t  next_state;
    wr_req_t req_q;
    logic    start_wb;
    logic    start_fill;

    if (line_count > MAX_LINES) begin : g_count_check
        $error("line_count exceeds MAX_LINES");
    end

    assign wr_ready    = (state == st_idle);
    assign wr_done     = (state == st_done);
    assign lookup_addr = req_q.addr;
    assign alloc       = (state == st_lookup) && (status != hit);
    assign install     = (state == st_install);
    assign mem_req     = (state == st_write);
    assign mark_dirty  = mem_req && gnt;

    assign mem_acc.we        = 1'b1;
    assign mem_acc.addr.slot = slot;
    assign mem_acc.addr.word = req_q.addr[LINE_OFFS_W-1:WORD_OFFS_W];
    assign mem_acc.data      = req_q.data;
    assign mem_acc.strb      = req_q.strb;

    // dirty victim goes out first, the fill follows its move_done
    assign start_wb   = (state == st_lookup) && (status == miss_dirty);
    assign start_fill = ((state == st_lookup) && (status == miss_clean)) ||
                        ((state == st_move) && move_done && (move_op == op_writeback));

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (wr_valid) begin
                    next_state = st_lookup;
                end
            end
            st_lookup: begin
                next_state = (status == hit) ? st_write : st_move;
            end
            st_move: begin
                if (move_done && move_op == op_fill) begin
                    next_state = st_install;
                end
            end
            st_install: begin
                next_state = st_write;
            end
            st_write: begin
                if (gnt) begin
                    next_state = st_done;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            move_start <= 1'b0;
        end else begin
            state      <= next_state;
            move_start <= start_wb || start_fill;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            req_q <= wr_req;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_lookup) begin
            move_slot <= slot;
        end
        if (start_wb) begin
            move_op   <= op_writeback;
            move_line <= victim_addr;
        end else if (start_fill) begin
            move_op   <= op_fill;
            move_line <= req_q.addr[ADDR_W-1:LINE_OFFS_W];
        end
    end

endmodule

// ==== source/line_mover.sv ====
`timescale 1ns/1ps

module line_mover (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        move_start,
    input  cache_msg_pkg::line_op_t     move_op,
    input  cache_geom_pkg::line_idx_t   move_slot,
    input  cache_geom_pkg::line_addr_t  move_line,
    input  logic                        fetch_gnt,
    input  logic                        fill_valid,
    input  cache_geom_pkg::word_t       fill_data,
    input  logic                        gnt,
    input  cache_geom_pkg::word_t       rdata,
    output logic                        move_done,
    output logic                        fetch_req,
    output cache_msg_pkg::fetch_cmd_t   fetch_cmd,
    output logic                        wb_valid,
    output cache_geom_pkg::word_t       wb_data,
    output logic                        mem_req,
    output cache_msg_pkg::mem_req_t     mem_acc
);
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    typedef enum logic [2:0] {
        m_idle,
        m_cmd,
        m_wb,
        m_drain,
        m_fill,
        m_done
    } state_t;

    state_t    state;
    line_idx_t slot_q;
    word_sel_t cnt_q;
    logic      fill_pend;
    word_t     fill_q;
    logic      last_word;
    logic      step;

    assign fetch_req = (state == m_cmd);
    assign move_done = (state == m_done);
    assign mem_req   = (state == m_wb) || (state == m_fill && fill_pend);
    assign step      = mem_req && gnt;
    assign last_word = (cnt_q == word_sel_t'(WORDS_PER_LINE - 1));

    assign mem_acc.we        = (state == m_fill);
    assign mem_acc.addr.slot = slot_q;
    assign mem_acc.addr.word = cnt_q;
    assign mem_acc.data      = fill_q;
    assign mem_acc.strb      = '1;

    // read data lands one cycle after each granted read
    assign wb_data = rdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= m_idle;
            cnt_q     <= '0;
            wb_valid  <= 1'b0;
            fill_pend <= 1'b0;
        end else begin
            wb_valid  <= (state == m_wb) && gnt;
            fill_pend <= (state == m_fill) && fill_valid;
            if (step) begin
                cnt_q <= cnt_q + 1'b1;
            end
            case (state)
                m_idle: begin
                    if (move_start) begin
                        state <= m_cmd;
                    end
                end
                m_cmd: begin
                    if (fetch_gnt) begin
                        cnt_q <= '0;
                        state <= (fetch_cmd.op == op_writeback) ? m_wb : m_fill;
                    end
                end
                m_wb: begin
                    if (step && last_word) begin
                        state <= m_drain;
                    end
                end
                m_drain: begin
                    state <= m_done;
                end
                m_fill: begin
                    if (step && last_word) begin
                        state <= m_done;
                    end
                end
                default: begin
                    state <= m_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == m_idle && move_start) begin
            slot_q              <= move_slot;
            fetch_cmd.op        <= move_op;
            fetch_cmd.line_addr <= move_line;
        end
        if (fill_valid) begin
            fill_q <= fill_data;
        end
    end

endmodule

// ==== source/wr_cache_top.sv ====
`timescale 1ns/1ps

module wr_cache_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       wr_valid,
    input  cache_msg_pkg::wr_req_t     wr_req,
    output logic                       wr_ready,
    output logic                       wr_done,
    output logic                       fetch_req,
    output cache_msg_pkg::fetch_cmd_t  fetch_cmd,
    input  logic                       fetch_gnt,
    output logic                       wb_valid,
    output cache_geom_pkg::word_t      wb_data,
    input  logic                       fill_valid,
    input  cache_geom_pkg::word_t      fill_data
);
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    localparam int line_count  = 4;
    localparam int num_clients = 2;

    addr_t            lookup_addr;
    logic             alloc;
    logic             install;
    logic             mark_dirty;
    lookup_status_t   status;
    line_idx_t        slot;
    line_addr_t       victim_addr;
    logic             move_start;
    line_op_t         move_op;
    line_idx_t        move_slot;
    line_addr_t       move_line;
    logic             move_done;
    logic             ctrl_mem_req;
    mem_req_t         ctrl_mem_acc;
    logic             mover_mem_req;
    mem_req_t         mover_mem_acc;
    logic [num_clients-1:0] arb_gnt;
    mem_req_t         store_acc;
    word_t            rdata;

    tag_directory #(.line_count(line_count)) u_dir (
        .clk(clk), .rst_n(rst_n), .lookup_addr(lookup_addr), .alloc(alloc),
        .install(install), .mark_dirty(mark_dirty), .status(status), .slot(slot),
        .victim_addr(victim_addr)
    );

    wr_ctrl #(.line_count(line_count)) u_ctrl (
        .clk(clk), .rst_n(rst_n), .wr_valid(wr_valid), .wr_req(wr_req),
        .status(status), .slot(slot), .victim_addr(victim_addr), .move_done(move_done),
        .gnt(arb_gnt[1]), .wr_ready(wr_ready), .wr_done(wr_done),
        .lookup_addr(lookup_addr), .alloc(alloc), .install(install),
        .mark_dirty(mark_dirty), .move_start(move_start), .move_op(move_op),
        .move_slot(move_slot), .move_line(move_line), .mem_req(ctrl_mem_req),
        .mem_acc(ctrl_mem_acc)
    );

    line_mover u_mover (
        .clk(clk), .rst_n(rst_n), .move_start(move_start), .move_op(move_op),
        .move_slot(move_slot), .move_line(move_line), .fetch_gnt(fetch_gnt),
        .fill_valid(fill_valid), .fill_data(fill_data), .gnt(arb_gnt[0]),
        .rdata(rdata), .move_done(move_done), .fetch_req(fetch_req),
        .fetch_cmd(fetch_cmd), .wb_valid(wb_valid), .wb_data(wb_data),
        .mem_req(mover_mem_req), .mem_acc(mover_mem_acc)
    );

    // mover is client 0 and always wins
    mem_arbiter #(.num_clients(num_clients)) u_arb (
        .req({ctrl_mem_req, mover_mem_req}), .acc({ctrl_mem_acc, mover_mem_acc}),
        .gnt(arb_gnt), .mem_acc(store_acc)
    );

    line_store u_store (
        .clk(clk), .mem_acc(store_acc), .mem_en(|arb_gnt), .rdata(rdata)
    );

endmodule

// ==== verif/wr_cache_assert.sv ====
`timescale 1ns/1ps

module wr_cache_assert (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      wr_valid,
    input logic                      wr_ready,
    input logic                      wr_done,
    input logic                      fetch_req,
    input logic                      fetch_gnt,
    input cache_msg_pkg::fetch_cmd_t fetch_cmd
);
    import cache_msg_pkg::*;

    logic busy;

    // set on accept, cleared by the done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (wr_valid && wr_ready) begin
            busy <= 1'b1;
        end else if (wr_done) begin
            busy <= 1'b0;
        end
    end

    cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_req && !fetch_gnt |=> $stable(fetch_cmd))
        else $error("fetch_cmd changed while waiting for grant");

    done_single: assert property (@(posedge clk) disable iff (!rst_n)
        wr_done |=> !wr_done)
        else $error("wr_done high for two cycles");

    ready_low: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !wr_ready)
        else $error("wr_ready high during an unfinished write");

endmodule

bind wr_cache_top wr_cache_assert u_assert (.*);

// ==== verif/wr_cache_tb.sv ====
`timescale 1ns/1ps

module wr_cache_tb;
    import cache_geom_pkg::*;
    import cache_msg_pkg::*;

    localparam int NUM_TESTS = 9;
    localparam int CYCLE_LIMIT = 200 * NUM_TESTS;

    // kind is 0 for a hit, 1 for a fill only and 2 for a writeback then a fill
    typedef struct packed {
        addr_t       addr;
        word_t       data;
        strb_t       strb;
        logic [1:0]  kind;
    } entry_t;

    logic       clk;
    logic       rst_n;
    logic       wr_valid;
    wr_req_t    wr_req;
    logic       wr_ready;
    logic       wr_done;
    logic       fetch_req;
    fetch_cmd_t fetch_cmd;
    logic       fetch_gnt;
    logic       wb_valid;
    word_t      wb_data;
    logic       fill_valid;
    word_t      fill_data;

    entry_t     tests [NUM_TESTS];
    fetch_cmd_t cmd_q [$];
    word_t      wb_q [$];
    word_t      fill_q [$];
    int         errors;
    int         cycles;
    int         accepts;
    int         dones;
    int         dly;
    logic       dly_set;
    int         fill_left;

    // reference directory
    line_addr_t m_tag [4];
    logic       m_valid [4];
    word_t      m_data [4][4];
    int         m_ptr;

    wr_cache_top u_dut (
        .clk(clk), .rst_n(rst_n), .wr_valid(wr_valid), .wr_req(wr_req),
        .wr_ready(wr_ready), .wr_done(wr_done), .fetch_req(fetch_req),
        .fetch_cmd(fetch_cmd), .fetch_gnt(fetch_gnt), .wb_valid(wb_valid),
        .wb_data(wb_data), .fill_valid(fill_valid), .fill_data(fill_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Done: errors found");
            $finish;
        end
    end

    // outside memory with a delayed grant and random fill words with gaps
    always @(posedge clk) begin
        if (rst_n) begin
            fill_valid <= 1'b0;
            if (wr_valid && wr_ready) accepts++;
            if (wr_done) dones++;
            if (wb_valid) wb_q.push_back(wb_data);
            if (fetch_req && fetch_gnt) begin
                fetch_gnt <= 1'b0;
                dly_set = 1'b0;
                cmd_q.push_back(fetch_cmd);
                if (fetch_cmd.op == op_fill) fill_left = 4;
            end else if (fetch_req) begin
                if (!dly_set) begin
                    dly = $urandom % 4;
                    dly_set = 1'b1;
                end
                if (dly == 0) fetch_gnt <= 1'b1;
                else dly--;
            end
            if (fill_left > 0 && ($urandom % 3) != 0) begin
                word_t w;
                w = $urandom;
                fill_valid <= 1'b1;
                fill_data <= w;
                fill_q.push_back(w);
                fill_left--;
            end
        end
    end

    task automatic mismatch(input string name, input word_t got, input word_t exp);
        $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic run_test(input int n);
        entry_t     e;
        line_addr_t line;
        int         hit_slot;
        int         slot;
        int         exp_cmds;
        int         err_before;
        fetch_cmd_t c;
        e = tests[n];
        line = e.addr[ADDR_W-1:LINE_OFFS_W];
        err_before = errors;
        hit_slot = -1;
        for (int i = 0; i < 4; i++) begin
            if (m_valid[i] && m_tag[i] == line) hit_slot = i;
        end
        exp_cmds = (hit_slot >= 0) ? 0 : (m_valid[m_ptr] ? 2 : 1);
        cmd_q.delete();
        wb_q.delete();
        fill_q.delete();
        wr_valid <= 1'b1;
        wr_req <= '{addr: e.addr, data: e.data, strb: e.strb};
        do @(posedge clk); while (!wr_ready);
        wr_valid <= 1'b0;
        do @(posedge clk); while (!wr_done);
        if (exp_cmds != e.kind) begin
            $display("test %0d: table expects %0d but directory model gives %0d",
                     n, e.kind, exp_cmds);
            errors++;
        end
        if (cmd_q.size() != exp_cmds) begin
            mismatch("fetch command count", cmd_q.size(), exp_cmds);
        end else if (exp_cmds > 0) begin
            if (exp_cmds == 2) begin
                c = cmd_q.pop_front();
                if (c.op != op_writeback) mismatch("fetch_cmd.op", c.op, op_writeback);
                if (c.line_addr != m_tag[m_ptr])
                    mismatch("fetch_cmd.line_addr", c.line_addr, m_tag[m_ptr]);
                if (wb_q.size() != 4) begin
                    mismatch("writeback word count", wb_q.size(), 4);
                end else begin
                    for (int w = 0; w < 4; w++) begin
                        if (wb_q[w] != m_data[m_ptr][w])
                            mismatch("wb_data", wb_q[w], m_data[m_ptr][w]);
                    end
                end
            end
            c = cmd_q.pop_front();
            if (c.op != op_fill) mismatch("fetch_cmd.op", c.op, op_fill);
            if (c.line_addr != line) mismatch("fetch_cmd.line_addr", c.line_addr, line);
        end
        if (exp_cmds != 2 && wb_q.size() != 0) begin
            mismatch("writeback word count", wb_q.size(), 0);
        end
        if (hit_slot < 0) begin
            if (fill_q.size() != 4) begin
                $display("test %0d: fill responder sent %0d words", n, fill_q.size());
                errors++;
            end
            slot = m_ptr;
            m_tag[slot] = line;
            m_valid[slot] = 1'b1;
            for (int w = 0; w < 4; w++) m_data[slot][w] = fill_q[w];
            m_ptr = (m_ptr + 1) % 4;
        end else begin
            slot = hit_slot;
        end
        // byte merge under the strobes
        for (int b = 0; b < 4; b++) begin
            if (e.strb[b])
                m_data[slot][e.addr[3:2]][b*8 +: 8] = e.data[b*8 +: 8];
        end
        $display("test %0d addr %h: %s", n, e.addr, (errors == err_before) ? "ok" : "FAIL");
    endtask

    initial begin
        void'($urandom(99));
        clk = 1'b0;
        rst_n = 1'b0;
        wr_valid = 1'b0;
        wr_req = '0;
        fetch_gnt = 1'b0;
        fill_valid = 1'b0;
        fill_data = '0;
        errors = 0;
        cycles = 0;
        accepts = 0;
        dones = 0;
        dly = 0;
        dly_set = 1'b0;
        fill_left = 0;
        m_ptr = 0;
        for (int i = 0; i < 4; i++) m_valid[i] = 1'b0;
        tests[0] = '{32'h0000_0100, 32'h1111_1111, 4'b1111, 2'd1};
        tests[1] = '{32'h0000_0104, 32'h2222_2222, 4'b1111, 2'd0};
        tests[2] = '{32'h0000_020c, 32'h3333_3333, 4'b0101, 2'd1};
        tests[3] = '{32'h0000_0300, 32'h4444_4444, 4'b1111, 2'd1};
        tests[4] = '{32'h0000_0408, 32'h5555_5555, 4'b1100, 2'd1};
        tests[5] = '{32'h0000_0500, 32'h6666_6666, 4'b1111, 2'd2};
        tests[6] = '{32'h0000_0208, 32'h7777_7777, 4'b0011, 2'd0};
        tests[7] = '{32'h0000_0100, 32'h8888_8888, 4'b0010, 2'd2};
        tests[8] = '{32'h0000_030c, 32'h9999_9999, 4'b1000, 2'd0};
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        for (int n = 0; n < NUM_TESTS; n++) begin
            run_test(n);
        end
        repeat (2) @(posedge clk);
        if (dones != accepts || accepts != NUM_TESTS) begin
            $display("done pulses %0d do not match accepted writes %0d", dones, accepts);
            errors++;
        end
        $display("tests %0d, errors %0d", NUM_TESTS, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/cache_geom_pkg.sv
source/cache_msg_pkg.sv
source/tag_directory.sv
source/mem_arbiter.sv
source/line_store.sv
source/wr_ctrl.sv
source/line_mover.sv
source/wr_cache_top.sv
verif/wr_cache_assert.sv
verif/wr_cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module wr_cache_tb -f verilog.f -o sim_wr_cache

./obj_dir/sim_wr_cache > sim.log
cat sim.log

if grep -q "Done: errors found" sim.log; then
    exit 1
fi
exit 0
